// File: hdl/rsa_arith_pkg.sv
`default_nettype none

package rsa_arith_pkg;

	// operand width used when the top level is not overridden
	localparam int DEF_WIDTH = 256;

	// wide enough to hold 0..256 inclusive
	localparam int IDX_BITS = 9;

	// counts doubling rounds, multiplier iterations and exponent bits
	typedef logic [IDX_BITS-1:0] bit_idx_t;

endpackage

`default_nettype wire

// File: hdl/rsa_ctrl_pkg.sv
`default_nettype none

package rsa_ctrl_pkg;

	// exponent ladder sequencing
	typedef enum logic [1:0] {
		LD_IDLE   = 2'd0,
		LD_LAUNCH = 2'd1, // start both multipliers
		LD_WAIT   = 2'd2,
		LD_STEP   = 2'd3  // fold products into t and m
	} ladder_state_t;

	// bit-serial units: multiplier and modulo product
	typedef enum logic [1:0] {
		SR_IDLE   = 2'd0,
		SR_RUN    = 2'd1,
		SR_FINISH = 2'd2
	} serial_state_t;

endpackage

`default_nettype wire

// File: hdl/rsa_job_if.sv
`timescale 1ns/100ps
`default_nettype none

// one prepared job: modulus, exponent and base in montgomery form
interface rsa_job_if
	import rsa_arith_pkg::*;
#(
	parameter int W = DEF_WIDTH
);

	logic         valid; // level, held until take
	logic         take;  // one-cycle pulse, only while valid
	logic [W-1:0] n;
	logic [W-1:0] d;
	logic [W-1:0] abar;  // a * 2^W mod n

	modport producer (
		output valid,
		output n,
		output d,
		output abar,
		input  take
	);

	modport consumer (
		input  valid,
		input  n,
		input  d,
		input  abar,
		output take
	);

endinterface

`default_nettype wire

// File: hdl/rsa_mont_mul.sv
`timescale 1ns/100ps
`default_nettype none

// p = a * b * 2^-W mod n, one bit of a per cycle
module rsa_mont_mul
	import rsa_arith_pkg::*, rsa_ctrl_pkg::*;
#(
	parameter int W = 256
) (
	input  logic         i_clk,
	input  logic         i_rst,
	input  logic         i_start,
	input  logic [W-1:0] i_a,
	input  logic [W-1:0] i_b,
	input  logic [W-1:0] i_n,
	output logic [W-1:0] o_p,
	output logic         o_done
);

	serial_state_t state_r;
	bit_idx_t      cnt_r;
	logic          done_r;

	logic [W-1:0]  a_sh_r;  // bits of a, lsb first
	logic [W-1:0]  b_r;
	logic [W-1:0]  n_r;
	logic [W:0]    acc_r;   // stays below 2n
	logic [W-1:0]  p_r;

	logic [W+1:0]  sum_add;
	logic [W+1:0]  sum_even;
	logic [W:0]    acc_sub;

	always_comb begin
		sum_add  = {1'b0, acc_r} + (a_sh_r[0] ? {2'b00, b_r} : {(W+2){1'b0}});
		// add n when odd so the halving is exact
		sum_even = sum_add + (sum_add[0] ? {2'b00, n_r} : {(W+2){1'b0}});
		acc_sub  = acc_r - {1'b0, n_r};
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r <= SR_IDLE;
			cnt_r   <= '0;
			done_r  <= 1'b0;
		end else begin
			done_r <= 1'b0;
			case (state_r)
				SR_IDLE: begin
					if (i_start) begin
						state_r <= SR_RUN;
						cnt_r   <= '0;
					end
				end
				SR_RUN: begin
					cnt_r <= cnt_r + 1'b1;
					if (cnt_r == bit_idx_t'(W - 1))
						state_r <= SR_FINISH;
				end
				SR_FINISH: begin
					state_r <= SR_IDLE;
					done_r  <= 1'b1; // result lands in p_r on this edge too
				end
				default: state_r <= SR_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state_r == SR_IDLE && i_start) begin
			a_sh_r <= i_a;
			b_r    <= i_b;
			n_r    <= i_n;
			acc_r  <= '0;
		end else if (state_r == SR_RUN) begin
			a_sh_r <= a_sh_r >> 1;
			acc_r  <= sum_even[W+1:1];
		end
		if (state_r == SR_FINISH)
			p_r <= (acc_r >= {1'b0, n_r}) ? acc_sub[W-1:0] : acc_r[W-1:0];
	end

	assign o_p    = p_r;
	assign o_done = done_r;

	// the ladder must not relaunch until it has seen done
	a_no_start_on_done: assert property (@(posedge i_clk) disable iff (i_rst)
		o_done |-> !i_start);

endmodule

`default_nettype wire

// File: hdl/rsa_mod_product.sv
`timescale 1ns/100ps
`default_nettype none

// moves the base into montgomery form: abar = a * 2^W mod n
module rsa_mod_product
	import rsa_arith_pkg::*, rsa_ctrl_pkg::*;
#(
	parameter int W = 256
) (
	input  logic         i_clk,
	input  logic         i_rst,
	input  logic         i_start,
	input  logic [W-1:0] i_a,
	input  logic [W-1:0] i_d,
	input  logic [W-1:0] i_n,
	output logic         o_ready,
	rsa_job_if.producer  o_job
);

	serial_state_t state_r;
	bit_idx_t      cnt_r;
	logic          valid_r;

	logic [W-1:0]  x_r;     // a * 2^cnt mod n
	logic [W-1:0]  n_r;
	logic [W-1:0]  d_r;
	logic [W-1:0]  abar_r;

	logic [W:0]    x_dbl;
	logic [W:0]    x_red;
	logic [W-1:0]  x_next;

	assign x_dbl  = {x_r, 1'b0};
	assign x_red  = x_dbl - {1'b0, n_r};
	assign x_next = (x_dbl >= {1'b0, n_r}) ? x_red[W-1:0] : x_dbl[W-1:0];

	assign o_ready    = (state_r == SR_IDLE);
	assign o_job.valid = valid_r;
	assign o_job.n     = n_r;
	assign o_job.d     = d_r;
	assign o_job.abar  = abar_r;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r <= SR_IDLE;
			cnt_r   <= '0;
			valid_r <= 1'b0;
		end else begin
			case (state_r)
				SR_IDLE: begin
					if (i_start) begin
						state_r <= SR_RUN;
						cnt_r   <= '0;
					end
				end
				SR_RUN: begin
					cnt_r <= cnt_r + 1'b1;
					if (cnt_r == bit_idx_t'(W))
						state_r <= SR_FINISH;
				end
				SR_FINISH: begin
					if (!valid_r) begin
						valid_r <= 1'b1;
					end else if (o_job.take) begin
						valid_r <= 1'b0;
						state_r <= SR_IDLE;
					end
				end
				default: state_r <= SR_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_ready && i_start) begin
			x_r <= i_a;
			n_r <= i_n;
			d_r <= i_d;
		end else if (state_r == SR_RUN) begin
			if (cnt_r == bit_idx_t'(W))
				abar_r <= x_r; // only bit W of 2^W is set
			else
				x_r <= x_next;
		end
	end

	a_valid_held: assert property (@(posedge i_clk) disable iff (i_rst)
		o_job.valid && !o_job.take |=> o_job.valid && $stable(o_job.abar));

endmodule

`default_nettype wire

// File: hdl/rsa_job_buffer.sv
`timescale 1ns/100ps
`default_nettype none

// single slot between precompute and ladder
module rsa_job_buffer #(
	parameter int W = 256
) (
	input  logic        i_clk,
	input  logic        i_rst,
	rsa_job_if.consumer i_job,
	rsa_job_if.producer o_job
);

	logic         full_r;
	logic [W-1:0] n_r;
	logic [W-1:0] d_r;
	logic [W-1:0] abar_r;
	logic         load;

	// a full slot still accepts in the cycle it drains
	assign load       = i_job.valid && (!full_r || o_job.take);
	assign i_job.take = load;

	assign o_job.valid = full_r;
	assign o_job.n     = n_r;
	assign o_job.d     = d_r;
	assign o_job.abar  = abar_r;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			full_r <= 1'b0;
		end else if (load) begin
			full_r <= 1'b1;
		end else if (o_job.take) begin
			full_r <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			n_r    <= i_job.n;
			d_r    <= i_job.d;
			abar_r <= i_job.abar;
		end
	end

	// held job is never overwritten before the ladder takes it
	a_no_overwrite: assert property (@(posedge i_clk) disable iff (i_rst)
		full_r && !o_job.take |=> o_job.valid && $stable(o_job.n)
			&& $stable(o_job.d) && $stable(o_job.abar));

endmodule

`default_nettype wire

// File: hdl/rsa_exp_ladder.sv
`timescale 1ns/100ps
`default_nettype none

// right-to-left square and multiply over W+4 cycles per exponent bit
module rsa_exp_ladder
	import rsa_arith_pkg::*, rsa_ctrl_pkg::*;
#(
	parameter int W = 256
) (
	input  logic         i_clk,
	input  logic         i_rst,
	rsa_job_if.consumer  i_job,
	output logic [W-1:0] o_result,
	output logic         o_finished
);

	ladder_state_t state_r;
	bit_idx_t      cnt_r;
	logic          fin_r;

	logic [W-1:0]  n_r;
	logic [W-1:0]  d_sh_r;   // remaining exponent bits with the next one at lsb
	logic [W-1:0]  t_r;      // a^(2^i) in montgomery form
	logic [W-1:0]  m_r;      // running product, plain form
	logic [W-1:0]  result_r;

	logic          launch;
	logic          last_bit;
	logic [W-1:0]  sq_p;
	logic [W-1:0]  mul_p;
	logic          sq_done;

	assign launch     = (state_r == LD_LAUNCH);
	assign last_bit   = (cnt_r == bit_idx_t'(W - 1));
	assign i_job.take = i_job.valid && (state_r == LD_IDLE);

	assign o_result   = result_r;
	assign o_finished = fin_r;

	rsa_mont_mul #(
		.W (W)
	) sq_mul_i (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (launch),
		.i_a     (t_r),
		.i_b     (t_r),
		.i_n     (n_r),
		.o_p     (sq_p),
		.o_done  (sq_done)
	);

	// same latency as the squarer, so its done is not needed
	rsa_mont_mul #(
		.W (W)
	) mt_mul_i (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (launch),
		.i_a     (m_r),
		.i_b     (t_r),
		.i_n     (n_r),
		.o_p     (mul_p),   // m * t * 2^-W keeps m in plain form
		.o_done  ()
	);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r <= LD_IDLE;
			cnt_r   <= '0;
			fin_r   <= 1'b0;
		end else begin
			fin_r <= 1'b0;
			case (state_r)
				LD_IDLE: begin
					if (i_job.take) begin
						state_r <= LD_LAUNCH;
						cnt_r   <= '0;
					end
				end
				LD_LAUNCH: state_r <= LD_WAIT;
				LD_WAIT: begin
					if (sq_done)
						state_r <= LD_STEP;
				end
				LD_STEP: begin
					cnt_r <= cnt_r + 1'b1;
					if (last_bit) begin
						state_r <= LD_IDLE;
						fin_r   <= 1'b1;
					end else begin
						state_r <= LD_LAUNCH;
					end
				end
				default: state_r <= LD_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_job.take) begin
			n_r    <= i_job.n;
			d_sh_r <= i_job.d;
			t_r    <= i_job.abar;
			m_r    <= W'(1);
		end else if (state_r == LD_STEP) begin
			t_r    <= sq_p;
			d_sh_r <= d_sh_r >> 1;
			if (d_sh_r[0])
				m_r <= mul_p;
			if (last_bit)
				result_r <= d_sh_r[0] ? mul_p : m_r;
		end
	end

	// both products come back fully reduced below n
	a_products_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
		state_r == LD_STEP |-> sq_p < n_r && mul_p < n_r);

endmodule

`default_nettype wire

// File: hdl/rsa256_core.sv
`timescale 1ns/100ps
`default_nettype none

// precompute -> one-entry buffer -> exponent ladder
module rsa256_core
	import rsa_arith_pkg::*;
#(
	parameter int W = DEF_WIDTH
) (
	input  logic         i_clk,
	input  logic         i_rst,
	input  logic         i_start,
	input  logic [W-1:0] i_a,
	input  logic [W-1:0] i_d,
	input  logic [W-1:0] i_n,
	output logic         o_ready,
	output logic [W-1:0] o_result,
	output logic         o_finished
);

	rsa_job_if #(.W(W)) prod_job ();
	rsa_job_if #(.W(W)) cons_job ();

	rsa_mod_product #(
		.W (W)
	) mod_product_i (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (i_start), // dropped unless o_ready
		.i_a     (i_a),
		.i_d     (i_d),
		.i_n     (i_n),
		.o_ready (o_ready),
		.o_job   (prod_job.producer)
	);

	rsa_job_buffer #(
		.W (W)
	) job_buffer_i (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_job (prod_job.consumer),
		.o_job (cons_job.producer)
	);

	rsa_exp_ladder #(
		.W (W)
	) exp_ladder_i (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_job      (cons_job.consumer),
		.o_result   (o_result),
		.o_finished (o_finished)
	);

endmodule

`default_nettype wire

// File: test/rsa_checker.sv
`timescale 1ns/100ps
`default_nettype none

// in-order scoreboard for o_finished results
module rsa_checker #(
	parameter int W         = 256,
	parameter int NAME_BITS = 128
) (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_finished,
	input  logic [W-1:0]         i_result,
	input  logic                 i_push,      // one job accepted by the DUT
	input  logic [NAME_BITS-1:0] i_push_name,
	input  logic [W-1:0]         i_push_exp,
	input  logic                 i_end,       // no more results expected
	output int                   o_seen,
	output int                   o_pass,
	output int                   o_fail,
	output int                   o_err
);

	logic [W-1:0]         exp_q[$];
	logic [NAME_BITS-1:0] name_q[$];
	int                   seen_n   = 0;
	int                   pass_n   = 0;
	int                   fail_n   = 0;
	int                   err_n    = 0;
	bit                   end_done = 1'b0;

	always @(posedge i_clk) begin : compare
		logic [W-1:0]         exp_v;
		logic [NAME_BITS-1:0] name_v;
		if (!i_rst) begin
			if (i_push) begin
				exp_q.push_back(i_push_exp);
				name_q.push_back(i_push_name);
			end
			if (i_finished) begin
				if (exp_q.size() == 0) begin
					$display("ERROR: o_finished pulsed with no job outstanding, o_result = %h",
						i_result);
					err_n++;
				end else begin
					exp_v  = exp_q.pop_front();
					name_v = name_q.pop_front();
					seen_n++;
					if (i_result === exp_v) begin
						$display("PASS %0s", name_v);
						pass_n++;
					end else begin
						$display("FAIL %0s expected %h actual %h", name_v, exp_v, i_result);
						fail_n++;
					end
				end
			end
			if (i_end && !end_done) begin
				end_done = 1'b1;
				if (exp_q.size() != 0) begin
					$display("ERROR: %0d accepted jobs never finished", exp_q.size());
					err_n += exp_q.size();
				end
			end
		end
		// registered copies, read by the tb one edge later
		o_seen <= seen_n;
		o_pass <= pass_n;
		o_fail <= fail_n;
		o_err  <= err_n;
	end

endmodule

`default_nettype wire

// File: test/tb_rsa256.sv
`timescale 1ns/100ps
`default_nettype none

// jobs from test/rsa_input.txt, random gaps, one stray start while busy
module tb_rsa256
	import rsa_arith_pkg::*;
#(
	parameter int W = DEF_WIDTH
) ();

	localparam int NAME_BITS  = 8 * 16;
	localparam int JOB_CYCLES = W + 2 + W * (W + 4) + 10; // one job, no overlap

	logic                 clk = 1'b0;
	logic                 rst;
	logic                 start;
	logic [W-1:0]         a;
	logic [W-1:0]         d;
	logic [W-1:0]         n;
	logic                 ready;
	logic [W-1:0]         result;
	logic                 finished;

	logic                 push;
	logic [NAME_BITS-1:0] push_name;
	logic [W-1:0]         push_exp;
	logic                 check_end;
	logic                 results_in;
	int                   seen;
	int                   pass_cnt;
	int                   fail_cnt;
	int                   err_cnt;

	logic [W-1:0]         a_vec[$];
	logic [W-1:0]         d_vec[$];
	logic [W-1:0]         n_vec[$];
	logic [W-1:0]         exp_vec[$];
	logic [NAME_BITS-1:0] name_vec[$];
	int                   gap_vec[$];
	int                   ntests    = 0;
	int                   total_gap = 0;
	int                   limit     = 0;
	int                   cycle_cnt = 0;
	int                   tb_errors = 0;
	logic [31:0]          lcg_state = 32'hf437_7968;

	always #10 clk = ~clk;

	rsa256_core #(
		.W (W)
	) rsa256_core_i (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_start    (start),
		.i_a        (a),
		.i_d        (d),
		.i_n        (n),
		.o_ready    (ready),
		.o_result   (result),
		.o_finished (finished)
	);

	rsa_checker #(
		.W         (W),
		.NAME_BITS (NAME_BITS)
	) checker_i (
		.i_clk       (clk),
		.i_rst       (rst),
		.i_finished  (finished),
		.i_result    (result),
		.i_push      (push),
		.i_push_name (push_name),
		.i_push_exp  (push_exp),
		.i_end       (check_end),
		.o_seen      (seen),
		.o_pass      (pass_cnt),
		.o_fail      (fail_cnt),
		.o_err       (err_cnt)
	);

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [W-1:0] rand_word();
		logic [W-1:0] v;
		v = '0;
		for (int k = 0; k < W; k += 32)
			v = (v << 32) | W'(next_rand());
		return v;
	endfunction

	task automatic load_tests();
		int                   fd;
		int                   r;
		string                line;
		logic [NAME_BITS-1:0] name_v;
		logic [W-1:0]         a_v;
		logic [W-1:0]         d_v;
		logic [W-1:0]         n_v;
		logic [W-1:0]         e_v;
		fd = $fopen("test/rsa_input.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open test/rsa_input.txt");
			return;
		end
		while (!$feof(fd)) begin
			line   = "";
			name_v = '0;
			r = $fgets(line, fd);
			if (r == 0 || line.substr(0, 0) == "#")
				continue; // column legend
			r = $sscanf(line, "%s %h %h %h %h", name_v, a_v, d_v, n_v, e_v);
			if (r == 5) begin
				name_vec.push_back(name_v);
				a_vec.push_back(a_v);
				d_vec.push_back(d_v);
				n_vec.push_back(n_v);
				exp_vec.push_back(e_v);
			end
		end
		$fclose(fd);
		ntests = a_vec.size();
	endtask

	task automatic plan_gaps();
		int i;
		int g;
		for (i = 0; i < ntests; i++) begin
			g = int'(next_rand() >> 16) % 12;
			if (i % 3 == 1)
				g = 0; // start again as soon as o_ready returns
			gap_vec.push_back(g);
			total_gap += g;
		end
	endtask

	// waits for o_ready, then one start pulse; operands held until the next job
	task automatic issue_job(input int idx);
		while (!ready)
			@(posedge clk);
		start <= 1'b1;
		a     <= a_vec[idx];
		d     <= d_vec[idx];
		n     <= n_vec[idx];
		@(posedge clk);
		if (!ready) begin
			$display("ERROR: start for %0s was dropped although o_ready was high",
				name_vec[idx]);
			tb_errors++;
		end
		start     <= 1'b0;
		push      <= 1'b1;
		push_name <= name_vec[idx];
		push_exp  <= exp_vec[idx];
		@(posedge clk);
		push <= 1'b0;
		if (ready) begin
			$display("ERROR: o_ready stayed high after the start for %0s", name_vec[idx]);
			tb_errors++;
		end
	endtask

	// producer is busy here, so this pulse must not create a job
	task automatic poke_while_busy();
		start <= 1'b1;
		a     <= rand_word() >> 1;
		d     <= rand_word();
		n     <= rand_word() | W'(1);
		@(posedge clk);
		if (ready) begin
			$display("ERROR: o_ready was high during the start meant to be ignored");
			tb_errors++;
		end
		start <= 1'b0;
		@(posedge clk);
	endtask

	task automatic run_jobs();
		int i;
		limit = ntests * JOB_CYCLES + total_gap;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		if (!ready || finished) begin
			$display("ERROR: after reset o_ready is not high or o_finished is not low");
			tb_errors++;
		end
		for (i = 0; i < ntests; i++) begin
			repeat (gap_vec[i]) @(posedge clk);
			issue_job(i);
			if (i == 0)
				poke_while_busy();
		end
		while (seen < ntests)
			@(posedge clk);
		results_in <= 1'b1;
	endtask

	task automatic finish_run();
		repeat (JOB_CYCLES) @(posedge clk); // room for a surplus result to show up
		check_end <= 1'b1;
		repeat (2) @(posedge clk);
		$display("summary: %0d tests, %0d passed, %0d failed, %0d other errors",
			ntests, pass_cnt, fail_cnt, err_cnt + tb_errors);
		if (pass_cnt == ntests && fail_cnt == 0 && err_cnt == 0 && tb_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	initial begin
		rst        = 1'b1;
		start      = 1'b0;
		a          = '0;
		d          = '0;
		n          = '0;
		push       = 1'b0;
		push_name  = '0;
		push_exp   = '0;
		check_end  = 1'b0;
		results_in = 1'b0;
		load_tests();
		if (ntests == 0) begin
			$display("ERROR: no test vectors were read");
			$display("Test failures found");
			$finish;
		end else begin
			plan_gaps();
			run_jobs();
			finish_run();
		end
	end

	// watchdog, stops once every result is in
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (limit > 0 && !results_in && cycle_cnt >= limit) begin
			$display("ERROR: timeout after %0d cycles with %0d of %0d results",
				cycle_cnt, seen, ntests);
			$display("Test failures found");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: test/rsa_input.txt
# name a d n expected, one test per line, values in hex
# n is odd and a < n on every line
textbook_3_7_33 3 7 21 9
exp_zero 5c3e91a07d24b8f6e1d0937a48c2b5e6f09d1a3b7c4e82f5163a9d0be7c45f12 0 fffffffffffffffffffffffffffffffffffffffffffffffffffffffefffffc2f 1
exp_one 3a7f0c92e54b18d60f2c7a93b8e146d52c09f7a16d3e58b491f0a2c75e83d16b 1 ffffffff00000001000000000000000000000000ffffffffffffffffffffffff 3a7f0c92e54b18d60f2c7a93b8e146d52c09f7a16d3e58b491f0a2c75e83d16b
fermat_k1 9e1b7c3f24a8d065c7f3192e8b05d4a7163fe9c20da47b58e2c91f367a05b8d4 fffffffffffffffffffffffffffffffffffffffffffffffffffffffefffffc2e fffffffffffffffffffffffffffffffffffffffffffffffffffffffefffffc2f 1
fermat_p256 d4e8a1f70b3c62957e1f04adc58b23e96f07d4a1b2e9c8350a7f16d4c93b58e2 ffffffff00000001000000000000000000000000ffffffffffffffffffffffff ffffffff00000001000000000000000000000000ffffffffffffffffffffffff d4e8a1f70b3c62957e1f04adc58b23e96f07d4a1b2e9c8350a7f16d4c93b58e2
neg_one_odd c8a3f5e197b20d4c3e6a18f705d9c2b4e71f6a382b0c94d5f36e81a74d2c09b4 8f3d1c5ae92b70641d8ec3f5a07b2e6954c1f8d3b6e0a9273f58d4c1e20b7a93 c8a3f5e197b20d4c3e6a18f705d9c2b4e71f6a382b0c94d5f36e81a74d2c09b5 c8a3f5e197b20d4c3e6a18f705d9c2b4e71f6a382b0c94d5f36e81a74d2c09b4
mersenne_pow2 8000000000000000000000000000000000000000000000000000000000000000 6b1e94c0f27d358a0c9e4b17d53a86f21e7c0b94a8f35d2647b1e0c93d582a3a ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000000000040000000000000000000000000000000000000000000000000

// File: sources.f
hdl/rsa_arith_pkg.sv
hdl/rsa_ctrl_pkg.sv
hdl/rsa_job_if.sv
hdl/rsa_mont_mul.sv
hdl/rsa_mod_product.sv
hdl/rsa_job_buffer.sv
hdl/rsa_exp_ladder.sv
hdl/rsa256_core.sv
test/rsa_checker.sv
test/tb_rsa256.sv

// File: run_sim.sh
#!/bin/sh
# build the rsa256 testbench with verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_rsa256 \
	--Mdir obj_dir -o sim_rsa256 -f sources.f > build.log 2>&1 \
	|| { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/sim_rsa256 > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log
grep -q 'All tests passed!' sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
